//--- Makefile
# Verilator build and run of the hypervector bundling buffer

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= hv_bundle_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/bundle_counter_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "hv_params.svh"

module bundle_counter_array import hv_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,

    // vote step and counter clear strobes
    input  logic       accumulate_i,
    input  logic       clear_i,

    // core results and enables
    input  core_hv_t   core_hv_i,
    input  core_mask_t core_mask_i,

    // majority per dimension
    output hv_t        sign_o
);

    // per-dimension overflow flags, gathered for the check below
    logic [`HV_DIM-1:0] ovf;

    // one counter per dimension
    for (genvar d = 0; d < `HV_DIM; d++) begin : g_dim

        vote_cnt_t cnt_q;
        vote_cnt_t delta;
        vote_cnt_t sum_w;

        // net vote of this step, +1 / -1 per enabled core
        always_comb begin
            delta = '0;
            for (int c = 0; c < `NUM_CORES; c++) begin
                if (core_mask_i[c]) begin
                    // core c's bit d sits at c*HV_DIM + d
                    if (core_hv_i[c*`HV_DIM + d]) begin
                        delta = delta + vote_cnt_t'(1);
                    end else begin
                        delta = delta - vote_cnt_t'(1);
                    end
                end
            end
        end

        assign sum_w = cnt_q + delta;

        // signed overflow: operands agree in sign, result does not
        assign ovf[d] = (cnt_q[`CNT_W-1] == delta[`CNT_W-1]) &&
                        (sum_w[`CNT_W-1] != cnt_q[`CNT_W-1]);

        // clear has priority over accumulate
        always_ff @(posedge clk) begin
            if (reset_i || clear_i) begin
                cnt_q <= '0;
            end else if (accumulate_i) begin
                cnt_q <= sum_w;
            end
        end

        // strictly positive counter gives 1, ties and negatives give 0
        assign sign_o[d] = ~cnt_q[`CNT_W-1] & (|cnt_q);

    end

    // an accepted vote step must never wrap any counter
    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset_i)
        (accumulate_i && !clear_i) |-> (ovf == '0)
    ) else $error("vote counter overflow, ovf=%h", ovf);

endmodule

`default_nettype wire

//--- hw/hv_bundle_top.sv
`timescale 1ns/1ps
`default_nettype none

module hv_bundle_top import hv_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,

    // core results and per-core enables
    input  core_hv_t   core_hv_i,
    input  core_mask_t core_mask_i,

    // control strobes
    input  logic       accumulate_i,
    input  logic       clear_i,
    input  logic       start_i,

    // live bundled vector
    output hv_t        hv_sign_o,

    // beat stream
    output beat_t      beat_o,
    output logic       beat_valid_o,
    output logic       beat_last_o,
    output logic       busy_o
);

    // counters to packer
    hv_t       sign_w;

    // sequencer to packer
    logic      beat_sel_w;
    beat_idx_t beat_idx_w;
    logic      beat_last_w;

    // vote counters, sign is combinational from them
    bundle_counter_array i_counter_array (
        .clk          (clk),
        .reset_i      (reset_i),
        .accumulate_i (accumulate_i),
        .clear_i      (clear_i),
        .core_hv_i    (core_hv_i),
        .core_mask_i  (core_mask_i),
        .sign_o       (sign_w)
    );

    // beat index walker
    readout_sequencer i_sequencer (
        .clk          (clk),
        .reset_i      (reset_i),
        .start_i      (start_i),
        .accumulate_i (accumulate_i),
        .clear_i      (clear_i),
        .beat_sel_o   (beat_sel_w),
        .beat_idx_o   (beat_idx_w),
        .beat_last_o  (beat_last_w),
        .busy_o       (busy_o)
    );

    // slice register and strobes
    stream_packer i_packer (
        .clk          (clk),
        .reset_i      (reset_i),
        .sign_i       (sign_w),
        .beat_sel_i   (beat_sel_w),
        .beat_idx_i   (beat_idx_w),
        .beat_last_i  (beat_last_w),
        .beat_o       (beat_o),
        .beat_valid_o (beat_valid_o),
        .beat_last_o  (beat_last_o)
    );

    assign hv_sign_o = sign_w;

endmodule

`default_nettype wire

//--- hw/hv_params.svh
`ifndef HV_PARAMS_SVH
`define HV_PARAMS_SVH

// hypervector dimension, bits per vector
`define HV_DIM 256

// stream beat width, must divide HV_DIM
`define BEAT_W 64

// fixed number of core result inputs
`define NUM_CORES 6

// signed vote counter width
`define CNT_W 16

// derived beat count and index width (at least one bit)
`define NUM_BEATS (`HV_DIM / `BEAT_W)
`define BEAT_IDX_W ((`NUM_BEATS > 1) ? $clog2(`NUM_BEATS) : 1)

`endif

//--- hw/hv_pkg.sv
`include "hv_params.svh"

package hv_pkg;

    // one bundled or core hypervector
    typedef logic [`HV_DIM-1:0] hv_t;

    // all core results side by side, core 0 in the lowest slice
    typedef logic [`NUM_CORES*`HV_DIM-1:0] core_hv_t;

    // one enable bit per core
    typedef logic [`NUM_CORES-1:0] core_mask_t;

    // stream beat and its index
    typedef logic [`BEAT_W-1:0] beat_t;
    typedef logic [`BEAT_IDX_W-1:0] beat_idx_t;

    // per-dimension vote counter, two's complement
    typedef logic signed [`CNT_W-1:0] vote_cnt_t;

    // readout fsm
    typedef enum logic {
        SEQ_IDLE,
        SEQ_STREAM
    } seq_state_t;

endpackage

//--- hw/readout_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "hv_params.svh"

module readout_sequencer import hv_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,

    // readout request
    input  logic      start_i,

    // only watched by the readout-stability check
    input  logic      accumulate_i,
    input  logic      clear_i,

    // beat select towards the packer
    output logic      beat_sel_o,
    output beat_idx_t beat_idx_o,
    output logic      beat_last_o,
    output logic      busy_o
);

    // index of the final beat
    localparam beat_idx_t LAST_IDX = beat_idx_t'(`NUM_BEATS - 1);

    seq_state_t state_q;
    beat_idx_t  idx_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= SEQ_IDLE;
            idx_q   <= '0;
        end else begin
            case (state_q)
                SEQ_IDLE: begin
                    // start while streaming never reaches here, so it is dropped
                    if (start_i) begin
                        state_q <= SEQ_STREAM;
                        idx_q   <= '0;
                    end
                end
                SEQ_STREAM: begin
                    if (idx_q == LAST_IDX) begin
                        state_q <= SEQ_IDLE;
                        idx_q   <= '0;
                    end else begin
                        idx_q <= idx_q + beat_idx_t'(1);
                    end
                end
                default: begin
                    state_q <= SEQ_IDLE;
                end
            endcase
        end
    end

    // one select per streaming cycle, no gaps
    assign beat_sel_o  = (state_q == SEQ_STREAM);
    assign beat_idx_o  = idx_q;
    assign beat_last_o = beat_sel_o && (idx_q == LAST_IDX);
    assign busy_o      = beat_sel_o;

    // a second start during readout is lost
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (reset_i)
        busy_o |-> !start_i
    ) else $error("start_i while readout busy");

    // counters must hold still while their slices are being sampled
    a_stable_readout: assert property (
        @(posedge clk) disable iff (reset_i)
        busy_o |-> !(accumulate_i || clear_i)
    ) else $error("accumulate or clear during readout");

endmodule

`default_nettype wire

//--- hw/stream_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "hv_params.svh"

module stream_packer import hv_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,

    // bundled vector from the counters
    input  hv_t       sign_i,

    // select from the sequencer
    input  logic      beat_sel_i,
    input  beat_idx_t beat_idx_i,
    input  logic      beat_last_i,

    // output stream
    output beat_t     beat_o,
    output logic      beat_valid_o,
    output logic      beat_last_o
);

    beat_t beat_q;
    logic  valid_q;
    logic  last_q;

    // slice idx covers bits idx*BEAT_W upward, idx 0 lowest
    // data holds between beats
    always_ff @(posedge clk) begin
        if (beat_sel_i) begin
            beat_q <= sign_i[int'(beat_idx_i)*`BEAT_W +: `BEAT_W];
        end
    end

    // strobes follow the select by one cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= beat_sel_i;
            last_q  <= beat_sel_i && beat_last_i;
        end
    end

    assign beat_o       = beat_q;
    assign beat_valid_o = valid_q;
    assign beat_last_o  = last_q;

endmodule

`default_nettype wire

//--- src.f
+incdir+hw
hw/hv_pkg.sv
hw/bundle_counter_array.sv
hw/readout_sequencer.sv
hw/stream_packer.sv
hw/hv_bundle_top.sv
test/hv_bundle_tb.sv

//--- test/hv_bundle_tb.sv
`timescale 1ns/1ps

`include "hv_params.svh"

module hv_bundle_tb import hv_pkg::*; ();

    // timeout budget per trace line, plus a fixed margin
    localparam int    LINE_CYCLES = 20;
    localparam int    BASE_CYCLES = 100;
    localparam string TRACE_PATH  = "test/hv_bundle_trace.txt";

    logic       clk;
    logic       reset_i;
    core_hv_t   core_hv_i;
    core_mask_t core_mask_i;
    logic       accumulate_i;
    logic       clear_i;
    logic       start_i;
    hv_t        hv_sign_o;
    beat_t      beat_o;
    logic       beat_valid_o;
    logic       beat_last_o;
    logic       busy_o;

    // expected beats of the current readout
    beat_t exp_beats[$];
    logic  exp_last[$];

    int err_value;
    int err_protocol;
    int fd;
    int cycle_cnt;
    int cycle_limit;
    bit trace_ok;

    hv_bundle_top i_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .core_hv_i    (core_hv_i),
        .core_mask_i  (core_mask_i),
        .accumulate_i (accumulate_i),
        .clear_i      (clear_i),
        .start_i      (start_i),
        .hv_sign_o    (hv_sign_o),
        .beat_o       (beat_o),
        .beat_valid_o (beat_valid_o),
        .beat_last_o  (beat_last_o),
        .busy_o       (busy_o)
    );

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_hv(input string name, input hv_t exp_v, input hv_t act_v);
        if (act_v !== exp_v) begin
            $display("ERR %s: expected %h, got %h", name, exp_v, act_v);
            err_value++;
        end
    endtask

    task automatic check_beat(input string name, input beat_t exp_v, input beat_t act_v);
        if (act_v !== exp_v) begin
            $display("ERR %s: expected %h, got %h", name, exp_v, act_v);
            err_value++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("ERR %s: expected %h, got %h", name, exp_v, act_v);
            err_value++;
        end
    endtask

    function automatic int count_trace_lines();
        int cfd;
        int ch;
        int n;
        n = 0;
        cfd = $fopen(TRACE_PATH, "r");
        if (cfd == 0) begin
            return 0;
        end
        ch = $fgetc(cfd);
        while (ch != -1) begin
            if (ch == 10) begin
                n++;
            end
            ch = $fgetc(cfd);
        end
        $fclose(cfd);
        return n;
    endfunction

    task automatic report_bad_trace(input string what);
        $display("trace format error: %s", what);
        err_protocol++;
        trace_ok = 1'b0;
    endtask

    // rest of a comment line
    task automatic skip_line();
        int ch;
        ch = 0;
        while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
        end
    endtask

    task automatic apply_reset();
        reset_i = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
    endtask

    // mask, then one hypervector per core, core 0 first
    task automatic do_accumulate();
        core_mask_t mask;
        hv_t        vec;
        core_hv_t   packed_hv;
        int         rc;
        packed_hv = '0;
        rc = $fscanf(fd, " %h", mask);
        if (rc != 1) begin
            report_bad_trace("accumulate without a mask");
            return;
        end
        for (int c = 0; c < `NUM_CORES; c++) begin
            rc = $fscanf(fd, " %h", vec);
            if (rc != 1) begin
                report_bad_trace("accumulate with too few core vectors");
                return;
            end
            packed_hv[c*`HV_DIM +: `HV_DIM] = vec;
        end
        core_hv_i    = packed_hv;
        core_mask_i  = mask;
        accumulate_i = 1'b1;
        @(negedge clk);
        accumulate_i = 1'b0;
    endtask

    task automatic do_clear();
        clear_i = 1'b1;
        @(negedge clk);
        clear_i = 1'b0;
    endtask

    task automatic run_readout();
        logic [7:0] tag;
        logic       last_v;
        beat_t      beat_v;
        int         rc;
        int         got;
        exp_beats.delete();
        exp_last.delete();
        last_v = 1'b0;
        // beat list ends at the flagged beat
        while (trace_ok && last_v !== 1'b1) begin
            rc = $fscanf(fd, " %c %h %h", tag, last_v, beat_v);
            if (rc != 3 || tag != "B") begin
                report_bad_trace("readout without a complete beat list");
            end else begin
                exp_beats.push_back(beat_v);
                exp_last.push_back(last_v);
            end
        end
        if (!trace_ok) begin
            return;
        end
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        got = 0;
        // cyc 0 is the cycle after the start edge, data lags select by one
        for (int cyc = 0; cyc < `NUM_BEATS + 3; cyc++) begin
            check_bit("busy_o", cyc < `NUM_BEATS, busy_o);
            check_bit("beat_valid_o", cyc >= 1 && cyc <= `NUM_BEATS, beat_valid_o);
            if (beat_valid_o === 1'b1) begin
                if (got < exp_beats.size()) begin
                    check_beat("beat_o", exp_beats[got], beat_o);
                    check_bit("beat_last_o", exp_last[got], beat_last_o);
                end else begin
                    $display("extra beat %0d after the expected %0d beats",
                             got, exp_beats.size());
                    err_protocol++;
                end
                got++;
            end else begin
                check_bit("beat_last_o", 1'b0, beat_last_o);
            end
            @(negedge clk);
        end
        if (got < exp_beats.size()) begin
            $display("missing beats: %0d arrived, %0d expected", got, exp_beats.size());
            err_protocol++;
        end
    endtask

    // one command letter per line, see the trace header
    task automatic run_trace();
        logic [7:0] cmd;
        hv_t        exp_v;
        int         rc;
        while (trace_ok) begin
            rc = $fscanf(fd, " %c", cmd);
            if (rc != 1) begin
                break;
            end
            case (cmd)
                "#": skip_line();
                "A": do_accumulate();
                "C": do_clear();
                "R": run_readout();
                "S": begin
                    rc = $fscanf(fd, " %h", exp_v);
                    if (rc != 1) begin
                        report_bad_trace("sign check without a vector");
                    end else begin
                        check_hv("hv_sign_o", exp_v, hv_sign_o);
                    end
                end
                default: begin
                    report_bad_trace("unknown command letter");
                end
            endcase
        end
    endtask

    // watchdog, limit scales with the trace length
    initial begin
        cycle_limit = count_trace_lines() * LINE_CYCLES + BASE_CYCLES;
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
        $display("errors: %0d value, %0d protocol", err_value, err_protocol);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        reset_i      = 1'b1;
        core_hv_i    = '0;
        core_mask_i  = '0;
        accumulate_i = 1'b0;
        clear_i      = 1'b0;
        start_i      = 1'b0;
        err_value    = 0;
        err_protocol = 0;
        trace_ok     = 1'b1;
        apply_reset();
        // idle outputs straight after reset
        check_hv("hv_sign_o", '0, hv_sign_o);
        check_bit("beat_valid_o", 1'b0, beat_valid_o);
        check_bit("beat_last_o", 1'b0, beat_last_o);
        check_bit("busy_o", 1'b0, busy_o);
        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0) begin
            $display("could not open the trace file %s", TRACE_PATH);
            err_protocol++;
        end else begin
            run_trace();
            $fclose(fd);
        end
        $display("errors: %0d value, %0d protocol", err_value, err_protocol);
        if (err_value + err_protocol == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- test/hv_bundle_trace.txt
# A <mask> then six hex hypervectors, core 0 first; C clear; S <expected sign vector>
# R readout, then one B <last> <beat> line per expected beat, lowest slice first
# reset state
S 0000000000000000000000000000000000000000000000000000000000000000
# all cores, 3-3 ties in the upper half give 0
A 3f
ffffffffffffffff0000000000000000aaaaaaaaaaaaaaaacccccccccccccccc
ffffffffffffffff00000000000000005555555555555555cccccccccccccccc
ffffffffffffffffffffffffffffffffaaaaaaaaaaaaaaaa3333333333333333
0000000000000000ffffffffffffffff55555555555555553333333333333333
0000000000000000ffffffffffffffffaaaaaaaaaaaaaaaacccccccccccccccc
00000000000000000000000000000000aaaaaaaaaaaaaaaa1111111111111111
S 00000000000000000000000000000000aaaaaaaaaaaaaaaa0000000000000000
# cores 0 and 2 only
A 05
ffffffffffffffffffffffffffffffff00000000000000006666666666666666
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
ffffffffffffffff333333333333333300000000000000006666666666666666
0000000000000000000000000000000000000000000000000000000000000000
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
S ffffffffffffffff333333333333333300000000000000004444444444444444
R
B 0 4444444444444444
B 0 0000000000000000
B 0 3333333333333333
B 1 ffffffffffffffff
# cores 1, 4 and 5 only
A 32
0000000000000000000000000000000000000000000000000000000000000000
0000000000000000ccccccccccccccccffffffffffffffff9999999999999999
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
0000000000000000000000000000000000000000000000000000000000000000
0000000000000000ccccccccccccccccffffffffffffffff1111111111111111
8888888888888888000000000000000077777777777777779999999999999999
S 8888888888888888ccccccccccccccccaaaaaaaaaaaaaaaa1111111111111111
R
B 0 1111111111111111
B 0 aaaaaaaaaaaaaaaa
B 0 cccccccccccccccc
B 1 8888888888888888
# repeat readout, same beats
R
B 0 1111111111111111
B 0 aaaaaaaaaaaaaaaa
B 0 cccccccccccccccc
B 1 8888888888888888
C
S 0000000000000000000000000000000000000000000000000000000000000000
R
B 0 0000000000000000
B 0 0000000000000000
B 0 0000000000000000
B 1 0000000000000000
# fresh start after clear, four cores vote x and two vote its complement
A 3f
0123456789abcdeffedcba987654321013579bdf02468ace5a5a5a5aa5a5a5a5
0123456789abcdeffedcba987654321013579bdf02468ace5a5a5a5aa5a5a5a5
0123456789abcdeffedcba987654321013579bdf02468ace5a5a5a5aa5a5a5a5
0123456789abcdeffedcba987654321013579bdf02468ace5a5a5a5aa5a5a5a5
fedcba98765432100123456789abcdefeca86420fdb97531a5a5a5a55a5a5a5a
fedcba98765432100123456789abcdefeca86420fdb97531a5a5a5a55a5a5a5a
S 0123456789abcdeffedcba987654321013579bdf02468ace5a5a5a5aa5a5a5a5
R
B 0 5a5a5a5aa5a5a5a5
B 0 13579bdf02468ace
B 0 fedcba9876543210
B 1 0123456789abcdef
